// ==== verilog/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // rv32i major opcodes.
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;
  localparam logic [6:0] op_fence  = 7'b0001111;

  // bit 3 picks sub or sra, low bits are funct3.
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_t;

  typedef struct packed {
    logic [31:0]     inst;
    logic [xlen-1:0] pc;
  } fetch_t;

  typedef struct packed {
    alu_op_t         alu_op;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] jump_base;
    logic [xlen-1:0] imm;
    logic [4:0]      rd;
    logic            rd_we;
    logic            is_jump;
    logic            is_branch;
    logic [2:0]      branch_f3;
    logic            mem_ren;
    logic            mem_wen;
    logic [2:0]      mem_f3;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] pc;
  } dec_t;

  typedef struct packed {
    logic            ren;
    logic            wen;
    logic [2:0]      f3;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
  } dmem_req_t;

  typedef struct packed {
    logic            done;
    logic [xlen-1:0] next_pc;
  } redirect_t;

endpackage

// ==== verilog/rv_ifu.sv ====
`timescale 1ns/1ps

module rv_ifu (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::redirect_t       redirect_i,
  input  logic                    idu_ready_i,
  input  logic                    imem_valid_i,
  input  logic [31:0]             imem_data_i,
  output logic                    imem_req_o,
  output logic [rv_pkg::xlen-1:0] imem_addr_o,
  output logic                    fetch_valid_o,
  output rv_pkg::fetch_t          fetch_o
);
  import rv_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_wait_inst,
    s_wait_redirect
  } state_t;

  state_t          state;
  logic [xlen-1:0] pc;

  assign imem_addr_o = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
      pc <= reset_pc;
      imem_req_o <= 1'b0;
      fetch_valid_o <= 1'b0;
    end else begin
      imem_req_o <= 1'b0;
      fetch_valid_o <= 1'b0;
      case (state)
        s_idle: begin
          if (idu_ready_i) begin
            imem_req_o <= 1'b1;
            state <= s_wait_inst;
          end
        end
        s_wait_inst: begin
          if (imem_valid_i) begin
            fetch_valid_o <= 1'b1;
            state <= s_wait_redirect;
          end
        end
        s_wait_redirect: begin
          // decode is normally ready again by now.
          if (redirect_i.done) begin
            pc <= redirect_i.next_pc;
            if (idu_ready_i) begin
              imem_req_o <= 1'b1;
              state <= s_wait_inst;
            end else begin
              state <= s_idle;
            end
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_wait_inst && imem_valid_i) begin
      fetch_o.inst <= imem_data_i;
      fetch_o.pc <= pc;
    end
  end

endmodule

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              rs1_i,
  input  logic [4:0]              rs2_i,
  output logic [rv_pkg::xlen-1:0] rdata1_o,
  output logic [rv_pkg::xlen-1:0] rdata2_o,
  input  logic                    we_i,
  input  logic [4:0]              waddr_i,
  input  logic [rv_pkg::xlen-1:0] wdata_i
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [32];

  // x0 is cleared by reset and never written, so it always reads zero.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

endmodule

// ==== verilog/rv_idu.sv ====
`timescale 1ns/1ps

module rv_idu (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_valid_i,
  input  rv_pkg::fetch_t          fetch_i,
  input  logic                    exu_ready_i,
  input  logic [rv_pkg::xlen-1:0] rdata1_i,
  input  logic [rv_pkg::xlen-1:0] rdata2_i,
  output logic                    idu_ready_o,
  output logic                    dec_valid_o,
  output rv_pkg::dec_t            dec_o,
  output logic [4:0]              rs1_o,
  output logic [4:0]              rs2_o
);
  import rv_pkg::*;

  typedef enum logic {
    s_idle,
    s_wait_ready
  } state_t;

  state_t          state;
  logic [31:0]     inst_q;
  logic [xlen-1:0] pc_q;

  logic [6:0]      opcode;
  logic [4:0]      rd;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
      dec_valid_o <= 1'b0;
      idu_ready_o <= 1'b1;
    end else begin
      case (state)
        s_idle: begin
          if (fetch_valid_i) begin
            dec_valid_o <= 1'b1;
            idu_ready_o <= 1'b0;
            state <= s_wait_ready;
          end
        end
        s_wait_ready: begin
          if (exu_ready_i) begin
            dec_valid_o <= 1'b0;
            idu_ready_o <= 1'b1;
            state <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // the record stays put while execute is busy.
  always_ff @(posedge clk) begin
    if (state == s_idle && fetch_valid_i) begin
      inst_q <= fetch_i.inst;
      pc_q <= fetch_i.pc;
    end
  end

  assign opcode = inst_q[6:0];
  assign rd     = inst_q[11:7];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign rs1_o  = inst_q[19:15];
  assign rs2_o  = inst_q[24:20];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  always_comb begin
    dec_o = '0;
    dec_o.alu_op = alu_add;
    dec_o.rd = rd;
    dec_o.pc = pc_q;
    case (opcode)
      op_lui: begin
        dec_o.op2 = imm_u;
        dec_o.rd_we = 1'b1;
      end
      op_auipc: begin
        dec_o.op1 = pc_q;
        dec_o.op2 = imm_u;
        dec_o.rd_we = 1'b1;
      end
      op_jal, op_jalr: begin
        // link value is pc plus 4.
        dec_o.op1 = pc_q;
        dec_o.op2 = 32'd4;
        dec_o.rd_we = 1'b1;
        dec_o.is_jump = 1'b1;
        dec_o.jump_base = (opcode == op_jal) ? pc_q : rdata1_i;
        dec_o.imm = (opcode == op_jal) ? imm_j : imm_i;
      end
      op_branch: begin
        dec_o.op1 = rdata1_i;
        dec_o.op2 = rdata2_i;
        dec_o.is_branch = 1'b1;
        dec_o.branch_f3 = funct3;
        dec_o.imm = imm_b;
      end
      op_imm: begin
        dec_o.alu_op = alu_op_t'({(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3});
        dec_o.op1 = rdata1_i;
        dec_o.op2 = imm_i;
        dec_o.rd_we = 1'b1;
      end
      op_reg: begin
        dec_o.alu_op = alu_op_t'({funct7[5], funct3});
        dec_o.op1 = rdata1_i;
        dec_o.op2 = rdata2_i;
        dec_o.rd_we = 1'b1;
      end
      op_load: begin
        dec_o.op1 = rdata1_i;
        dec_o.imm = imm_i;
        dec_o.rd_we = 1'b1;
        dec_o.mem_ren = 1'b1;
        dec_o.mem_f3 = funct3;
      end
      op_store: begin
        dec_o.op1 = rdata1_i;
        dec_o.imm = imm_s;
        dec_o.store_data = rdata2_i;
        dec_o.mem_wen = 1'b1;
        dec_o.mem_f3 = funct3;
      end
      op_system, op_fence: begin
        dec_o.rd_we = 1'b0;
      end
      default: begin
        dec_o.rd_we = 1'b0;
      end
    endcase
  end

endmodule

// ==== verilog/rv_exu.sv ====
`timescale 1ns/1ps

module rv_exu (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    dec_valid_i,
  input  rv_pkg::dec_t            dec_i,
  input  logic                    dmem_rvalid_i,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata_i,
  output logic                    exu_ready_o,
  output logic                    rf_we_o,
  output logic [4:0]              rf_waddr_o,
  output logic [rv_pkg::xlen-1:0] rf_wdata_o,
  output rv_pkg::dmem_req_t       dmem_req_o,
  output rv_pkg::redirect_t       redirect_o
);
  import rv_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_exec,
    s_store_done,
    s_load_wait,
    s_load_wb
  } state_t;

  state_t          state;
  dec_t            d_q;
  logic [xlen-1:0] ld_q;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] ld_word;
  logic [xlen-1:0] ld_ext;
  logic [xlen-1:0] next_pc;
  logic            br_taken;

  assign exu_ready_o = (state == s_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: begin
          if (dec_valid_i) begin
            state <= s_exec;
          end
        end
        s_exec: begin
          if (d_q.mem_ren) begin
            state <= s_load_wait;
          end else if (d_q.mem_wen) begin
            state <= s_store_done;
          end else begin
            state <= s_idle;
          end
        end
        s_load_wait: begin
          if (dmem_rvalid_i) begin
            state <= s_load_wb;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_idle && dec_valid_i) begin
      d_q <= dec_i;
    end
    if (state == s_load_wait && dmem_rvalid_i) begin
      ld_q <= dmem_rdata_i;
    end
  end

  always_comb begin
    case (d_q.alu_op)
      alu_sub:  alu_res = d_q.op1 - d_q.op2;
      alu_sll:  alu_res = d_q.op1 << d_q.op2[4:0];
      alu_slt:  alu_res = {31'b0, $signed(d_q.op1) < $signed(d_q.op2)};
      alu_sltu: alu_res = {31'b0, d_q.op1 < d_q.op2};
      alu_xor:  alu_res = d_q.op1 ^ d_q.op2;
      alu_srl:  alu_res = d_q.op1 >> d_q.op2[4:0];
      alu_sra:  alu_res = $signed(d_q.op1) >>> d_q.op2[4:0];
      alu_or:   alu_res = d_q.op1 | d_q.op2;
      alu_and:  alu_res = d_q.op1 & d_q.op2;
      default:  alu_res = d_q.op1 + d_q.op2;
    endcase
  end

  // beq, bne, blt, bge, bltu, bgeu.
  always_comb begin
    case (d_q.branch_f3)
      3'b000:  br_taken = (d_q.op1 == d_q.op2);
      3'b001:  br_taken = (d_q.op1 != d_q.op2);
      3'b100:  br_taken = ($signed(d_q.op1) < $signed(d_q.op2));
      3'b101:  br_taken = ($signed(d_q.op1) >= $signed(d_q.op2));
      3'b110:  br_taken = (d_q.op1 < d_q.op2);
      3'b111:  br_taken = (d_q.op1 >= d_q.op2);
      default: br_taken = 1'b0;
    endcase
  end

  always_comb begin
    if (d_q.is_jump) begin
      next_pc = (d_q.jump_base + d_q.imm) & ~32'd1;
    end else if (d_q.is_branch && br_taken) begin
      next_pc = d_q.pc + d_q.imm;
    end else begin
      next_pc = d_q.pc + 32'd4;
    end
  end

  assign mem_addr = d_q.op1 + d_q.imm;

  // memory returns the whole aligned word.
  assign ld_word = ld_q >> {mem_addr[1:0], 3'b000};

  always_comb begin
    case (d_q.mem_f3)
      3'b000:  ld_ext = {{24{ld_word[7]}}, ld_word[7:0]};
      3'b001:  ld_ext = {{16{ld_word[15]}}, ld_word[15:0]};
      3'b100:  ld_ext = {24'b0, ld_word[7:0]};
      3'b101:  ld_ext = {16'b0, ld_word[15:0]};
      default: ld_ext = ld_word;
    endcase
  end

  assign rf_we_o = d_q.rd_we && ((state == s_exec && !d_q.mem_ren) || state == s_load_wb);
  assign rf_waddr_o = d_q.rd;
  assign rf_wdata_o = (state == s_load_wb) ? ld_ext : alu_res;

  assign dmem_req_o.ren = (state == s_exec) && d_q.mem_ren;
  assign dmem_req_o.wen = (state == s_exec) && d_q.mem_wen;
  assign dmem_req_o.f3 = d_q.mem_f3;
  assign dmem_req_o.addr = mem_addr;
  assign dmem_req_o.wdata = d_q.store_data;

  assign redirect_o.done = (state == s_exec && !d_q.mem_ren && !d_q.mem_wen) ||
                           state == s_store_done || state == s_load_wb;
  assign redirect_o.next_pc = next_pc;

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    imem_valid_i,
  input  logic [31:0]             imem_data_i,
  input  logic                    dmem_rvalid_i,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata_i,
  output logic                    imem_req_o,
  output logic [rv_pkg::xlen-1:0] imem_addr_o,
  output rv_pkg::dmem_req_t       dmem_req_o
);
  import rv_pkg::*;

  redirect_t       redirect;
  fetch_t          fetch;
  logic            fetch_valid;
  logic            idu_ready;
  dec_t            dec;
  logic            dec_valid;
  logic            exu_ready;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic            rf_we;
  logic [4:0]      rf_waddr;
  logic [xlen-1:0] rf_wdata;

  rv_ifu i_rv_ifu (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect),
    .idu_ready_i   (idu_ready),
    .imem_valid_i  (imem_valid_i),
    .imem_data_i   (imem_data_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .fetch_valid_o (fetch_valid),
    .fetch_o       (fetch)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  rv_idu i_rv_idu (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid),
    .fetch_i       (fetch),
    .exu_ready_i   (exu_ready),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .idu_ready_o   (idu_ready),
    .dec_valid_o   (dec_valid),
    .dec_o         (dec),
    .rs1_o         (rs1),
    .rs2_o         (rs2)
  );

  rv_exu i_rv_exu (
    .clk           (clk),
    .rst           (rst),
    .dec_valid_i   (dec_valid),
    .dec_i         (dec),
    .dmem_rvalid_i (dmem_rvalid_i),
    .dmem_rdata_i  (dmem_rdata_i),
    .exu_ready_o   (exu_ready),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .dmem_req_o    (dmem_req_o),
    .redirect_o    (redirect)
  );

endmodule

// ==== tb/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::dmem_req_t dmem_req_i,
  input  int                row_i,
  input  logic [31:0]       exp_addr_i,
  input  logic [31:0]       exp_data_i,
  output logic              stored_o,
  output int                pass_cnt_o,
  output int                fail_cnt_o
);

  // every program ends in a word store.
  localparam logic [2:0] sw_f3 = 3'b010;

  initial begin
    stored_o = 1'b0;
    pass_cnt_o = 0;
    fail_cnt_o = 0;
  end

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [2:0] f3);
    logic good;
    good = 1'b1;
    if (addr !== exp_addr_i) begin
      $display("Mismatch at %0t ns: test %0d addr expected %08h got %08h",
               $time, row_i, exp_addr_i, addr);
      good = 1'b0;
    end
    if (data !== exp_data_i) begin
      $display("Mismatch at %0t ns: test %0d data expected %08h got %08h",
               $time, row_i, exp_data_i, data);
      good = 1'b0;
    end
    if (f3 !== sw_f3) begin
      $display("Mismatch at %0t ns: test %0d f3 expected %0d got %0d",
               $time, row_i, sw_f3, f3);
      good = 1'b0;
    end
    if (good) begin
      pass_cnt_o++;
      $display("test %0d: store ok", row_i);
    end else begin
      fail_cnt_o++;
      $display("test %0d: wrong store", row_i);
    end
  endtask

  // only the first store after reset belongs to the test.
  always @(posedge clk) begin
    if (rst) begin
      stored_o <= 1'b0;
    end else if (!stored_o && dmem_req_i.wen) begin
      stored_o <= 1'b1;
      check_store(dmem_req_i.addr, dmem_req_i.wdata, dmem_req_i.f3);
    end
  end

endmodule

// ==== tb/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;
  import rv_pkg::*;

  localparam int n_rows = 9;
  localparam int max_len = 16;
  // fetch, decode, execute and a slow load for one instruction.
  localparam int worst_instr_cycles = 12;
  localparam int cycle_limit = n_rows * max_len * worst_instr_cycles * 2;

  logic        clk;
  logic        rst;
  logic        imem_valid_i;
  logic [31:0] imem_data_i;
  logic        dmem_rvalid_i;
  logic [31:0] dmem_rdata_i;
  logic        imem_req_o;
  logic [31:0] imem_addr_o;
  dmem_req_t   dmem_req;

  logic [31:0] prog [n_rows][max_len];
  logic [31:0] exp_addr [n_rows];
  logic [31:0] exp_data [n_rows];
  logic [31:0] dmem [256];
  integer      seed;
  int          row;
  int          cycles;
  int          imem_wait;
  int          dmem_wait;
  logic [31:0] imem_addr_q;
  logic [31:0] dmem_addr_q;
  logic        stored;
  int          pass_cnt;
  int          fail_cnt;

  rv_core i_rv_core (
    .clk           (clk),
    .rst           (rst),
    .imem_valid_i  (imem_valid_i),
    .imem_data_i   (imem_data_i),
    .dmem_rvalid_i (dmem_rvalid_i),
    .dmem_rdata_i  (dmem_rdata_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .dmem_req_o    (dmem_req)
  );

  tb_checker i_tb_checker (
    .clk        (clk),
    .rst        (rst),
    .dmem_req_i (dmem_req),
    .row_i      (row),
    .exp_addr_i (exp_addr[row]),
    .exp_data_i (exp_data[row]),
    .stored_o   (stored),
    .pass_cnt_o (pass_cnt),
    .fail_cnt_o (fail_cnt)
  );

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // misaligned or out of range fetches land on a self-loop.
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr[1:0] != 2'b00 || addr >= 4 * max_len) begin
      return j_type(5'd0, 32'd0);
    end
    return prog[row][addr >> 2];
  endfunction

  // each not-taken branch adds its own bit to x10.
  task automatic branch_program(input int r, input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] addr, input logic [31:0] value);
    prog[r][0] = i_type(op_imm, 3'b000, 5'd1, 5'd0, a);
    prog[r][1] = i_type(op_imm, 3'b000, 5'd2, 5'd0, b);
    for (int k = 0; k < 6; k++) begin
      prog[r][2 + 2 * k] = b_type((k < 2) ? k : k + 2, 5'd1, 5'd2, 32'd8);
      prog[r][3 + 2 * k] = i_type(op_imm, 3'b000, 5'd10, 5'd10, 32'd1 << k);
    end
    prog[r][14] = s_type(3'b010, 5'd10, 5'd0, addr);
    exp_addr[r] = addr;
    exp_data[r] = value;
  endtask

  task automatic build_table;
    for (int r = 0; r < n_rows; r++) begin
      for (int s = 0; s < max_len; s++) begin
        prog[r][s] = j_type(5'd0, 32'd0);
      end
    end
    // lui, addi and auipc.
    prog[0][0] = u_type(op_lui, 5'd1, 20'h12345);
    prog[0][1] = i_type(op_imm, 3'b000, 5'd1, 5'd1, 32'h678);
    prog[0][2] = u_type(op_auipc, 5'd2, 20'h00001);
    prog[0][3] = r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    prog[0][4] = s_type(3'b010, 5'd3, 5'd0, 32'h100);
    exp_addr[0] = 32'h0000_0100;
    exp_data[0] = 32'h1234_6680;
    // srai, srli, sltiu and slti on a negative value.
    prog[1][0] = i_type(op_imm, 3'b000, 5'd1, 5'd0, -32'sd16);
    prog[1][1] = i_type(op_imm, 3'b101, 5'd2, 5'd1, 32'h402);
    prog[1][2] = i_type(op_imm, 3'b101, 5'd3, 5'd1, 32'd28);
    prog[1][3] = i_type(op_imm, 3'b011, 5'd4, 5'd1, 32'd5);
    prog[1][4] = i_type(op_imm, 3'b010, 5'd5, 5'd1, 32'd5);
    prog[1][5] = r_type(7'h00, 3'b000, 5'd6, 5'd2, 5'd3);
    prog[1][6] = r_type(7'h00, 3'b000, 5'd6, 5'd6, 5'd4);
    prog[1][7] = r_type(7'h00, 3'b000, 5'd6, 5'd6, 5'd5);
    prog[1][8] = s_type(3'b010, 5'd6, 5'd0, 32'h104);
    exp_addr[1] = 32'h0000_0104;
    exp_data[1] = 32'h0000_000c;
    // sub, sra, sltu, xor and a write to x0.
    prog[2][0] = i_type(op_imm, 3'b000, 5'd1, 5'd0, 32'd100);
    prog[2][1] = i_type(op_imm, 3'b000, 5'd2, 5'd0, -32'sd3);
    prog[2][2] = r_type(7'h20, 3'b000, 5'd3, 5'd1, 5'd2);
    prog[2][3] = r_type(7'h20, 3'b101, 5'd4, 5'd2, 5'd1);
    prog[2][4] = r_type(7'h00, 3'b011, 5'd5, 5'd1, 5'd2);
    prog[2][5] = r_type(7'h00, 3'b100, 5'd6, 5'd3, 5'd4);
    prog[2][6] = r_type(7'h00, 3'b000, 5'd0, 5'd1, 5'd1);
    prog[2][7] = r_type(7'h00, 3'b000, 5'd6, 5'd6, 5'd5);
    prog[2][8] = r_type(7'h00, 3'b000, 5'd6, 5'd6, 5'd0);
    prog[2][9] = s_type(3'b010, 5'd6, 5'd0, 32'h108);
    exp_addr[2] = 32'h0000_0108;
    exp_data[2] = 32'hffff_ff99;
    branch_program(3, -32'sd2, 32'd3, 32'h110, 32'h19);
    branch_program(4, 32'd3, -32'sd2, 32'h114, 32'h25);
    branch_program(5, 32'd5, 32'd5, 32'h118, 32'h16);
    // jal and jalr links, jalr target 21 rounds down to 20.
    prog[6][0] = j_type(5'd1, 32'd8);
    prog[6][1] = i_type(op_imm, 3'b000, 5'd10, 5'd10, 32'h100);
    prog[6][2] = i_type(op_imm, 3'b000, 5'd5, 5'd0, 32'd20);
    prog[6][3] = i_type(op_jalr, 3'b000, 5'd6, 5'd5, 32'd1);
    prog[6][4] = i_type(op_imm, 3'b000, 5'd10, 5'd10, 32'h200);
    prog[6][5] = i_type(op_imm, 3'b001, 5'd6, 5'd6, 32'd8);
    prog[6][6] = r_type(7'h00, 3'b000, 5'd7, 5'd6, 5'd1);
    prog[6][7] = r_type(7'h00, 3'b000, 5'd7, 5'd7, 5'd10);
    prog[6][8] = s_type(3'b010, 5'd7, 5'd0, 32'h11c);
    exp_addr[6] = 32'h0000_011c;
    exp_data[6] = 32'h0000_1004;
    // lb, lbu, lh, lhu and lw from the preset word at 0x200.
    prog[7][0] = i_type(op_load, 3'b000, 5'd1, 5'd0, 32'h201);
    prog[7][1] = i_type(op_load, 3'b100, 5'd2, 5'd0, 32'h201);
    prog[7][2] = i_type(op_load, 3'b001, 5'd3, 5'd0, 32'h202);
    prog[7][3] = i_type(op_load, 3'b101, 5'd4, 5'd0, 32'h200);
    prog[7][4] = i_type(op_load, 3'b010, 5'd5, 5'd0, 32'h200);
    prog[7][5] = r_type(7'h00, 3'b000, 5'd6, 5'd1, 5'd2);
    prog[7][6] = r_type(7'h00, 3'b000, 5'd6, 5'd6, 5'd3);
    prog[7][7] = r_type(7'h00, 3'b000, 5'd6, 5'd6, 5'd4);
    prog[7][8] = r_type(7'h00, 3'b000, 5'd6, 5'd6, 5'd5);
    prog[7][9] = s_type(3'b010, 5'd6, 5'd0, 32'h120);
    exp_addr[7] = 32'h0000_0120;
    exp_data[7] = 32'h8a5d_723e;
    // store with a negative offset.
    prog[8][0] = i_type(op_imm, 3'b000, 5'd1, 5'd0, 32'h300);
    prog[8][1] = i_type(op_imm, 3'b000, 5'd2, 5'd0, 32'h5a5);
    prog[8][2] = s_type(3'b010, 5'd2, 5'd1, -32'sd32);
    exp_addr[8] = 32'h0000_02e0;
    exp_data[8] = 32'h0000_05a5;
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // instruction and data memory models.
  always @(posedge clk) begin
    imem_valid_i <= 1'b0;
    dmem_rvalid_i <= 1'b0;
    if (rst) begin
      imem_wait <= 0;
      dmem_wait <= 0;
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
      end
      dmem[128] <= 32'h8a5c_f37e;
    end else begin
      if (imem_req_o) begin
        imem_wait <= 1 + {$random(seed)} % 3;
        imem_addr_q <= imem_addr_o;
      end else if (imem_wait == 1) begin
        imem_valid_i <= 1'b1;
        imem_data_i <= fetch_word(imem_addr_q);
        imem_wait <= 0;
      end else if (imem_wait > 1) begin
        imem_wait <= imem_wait - 1;
      end
      if (dmem_req.wen) begin
        case (dmem_req.f3[1:0])
          2'b00: dmem[dmem_req.addr[9:2]][8 * dmem_req.addr[1:0] +: 8] <= dmem_req.wdata[7:0];
          2'b01: dmem[dmem_req.addr[9:2]][16 * dmem_req.addr[1] +: 16] <= dmem_req.wdata[15:0];
          default: dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        endcase
      end
      if (dmem_req.ren) begin
        dmem_wait <= 1 + {$random(seed)} % 3;
        dmem_addr_q <= dmem_req.addr;
      end else if (dmem_wait == 1) begin
        dmem_rvalid_i <= 1'b1;
        dmem_rdata_i <= dmem[dmem_addr_q[9:2]];
        dmem_wait <= 0;
      end else if (dmem_wait > 1) begin
        dmem_wait <= dmem_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: test %0d never stored its result", row);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    seed = 32'ha731_391a;
    cycles = 0;
    row = 0;
    rst = 1'b1;
    imem_valid_i = 1'b0;
    imem_data_i = '0;
    dmem_rvalid_i = 1'b0;
    dmem_rdata_i = '0;
    build_table();
    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk);
      rst <= 1'b1;
      row <= r;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      while (!stored) begin
        @(posedge clk);
      end
    end
    $display("totals: %0d passed, %0d failed of %0d", pass_cnt, fail_cnt, n_rows);
    if (fail_cnt == 0 && pass_cnt == n_rows) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/rv_pkg.sv
verilog/rv_ifu.sv
verilog/rv_regfile.sv
verilog/rv_idu.sv
verilog/rv_exu.sv
verilog/rv_core.sv
tb/tb_checker.sv
tb/tb_core.sv
